// ==== rp_analog_settings.svh ====
// Analog path settings

`ifndef RP_ANALOG_SETTINGS_SVH
`define RP_ANALOG_SETTINGS_SVH

//////////////////////////////
// Data widths
//////////////////////////////

`define RP_ADC_DW 16   // ADC sample width
`define RP_DAC_DW 14   // DAC sample width

//////////////////////////////
// System bus
//////////////////////////////

`define RP_SYS_AW 20   // Byte address
`define RP_SYS_DW 32   // Read and write data

// Region field is addr[19:16]
`define RP_REGION_MSB 19
`define RP_REGION_HK  0  // House-keeping
`define RP_REGION_PID 1  // Controller

//////////////////////////////
// Misc
//////////////////////////////

`define RP_PDM_N    4             // Slow analog outputs
`define RP_PDM_DW   8             // PDM level width
`define RP_KP_SHIFT 8             // Gain has 8 fractional bits
`define RP_ID_VALUE 32'h5250_4131 // Design ID word

`endif

// ==== rp_analog_pkg.sv ====
// Analog path types

`default_nettype none

`include "rp_analog_settings.svh"

package rp_analog_pkg;

  //////////////////////////////
  // System bus
  //////////////////////////////

  // Master to slave, strobes last one cycle
  typedef struct packed {
    logic [`RP_SYS_AW-1:0] addr;
    logic [`RP_SYS_DW-1:0] wdata;
    logic                  wen;   // Write strobe
    logic                  ren;   // Read strobe
  } sys_req_t;

  // Slave to master, one cycle after the strobe
  typedef struct packed {
    logic [`RP_SYS_DW-1:0] rdata; // Valid with ack
    logic                  ack;
    logic                  err;   // Only together with ack
  } sys_rsp_t;

  //////////////////////////////
  // Data path words
  //////////////////////////////

  typedef logic signed [`RP_ADC_DW-1:0] adc_word_t;
  typedef logic signed [`RP_DAC_DW-1:0] dac_word_t;

  typedef struct packed {
    dac_word_t a;
    dac_word_t b;
  } dac_pair_t;

  typedef struct packed {
    adc_word_t a;
    adc_word_t b;
  } adc_pair_t;

  // House-keeping settings seen by the data path
  typedef struct packed {
    logic                  digital_loop; // DAC back into ADC path
    dac_word_t             dc_a;
    dac_word_t             dc_b;
    logic [8-1:0]          led;
  } hk_cfg_t;

  // One level per slow output
  typedef logic [`RP_PDM_N-1:0][`RP_PDM_DW-1:0] pdm_cfg_t;

endpackage

`default_nettype wire

// ==== sys_bus_decoder.sv ====
// System bus region decoder

`timescale 1ns/1ps
`default_nettype none

`include "rp_analog_settings.svh"

module sys_bus_decoder
  import rp_analog_pkg::*;
(
  input  wire logic     adc_clk,
  input  wire logic     rst_i,
  // Master side
  input  wire sys_req_t m_req_i,
  output sys_rsp_t      m_rsp_o,
  // House-keeping slave
  output sys_req_t      hk_req_o,
  input  wire sys_rsp_t hk_rsp_i,
  // Controller slave
  output sys_req_t      pid_req_o,
  input  wire sys_rsp_t pid_rsp_i
);

  localparam int REGION_W   = 4;
  localparam int REGION_LSB = `RP_REGION_MSB - REGION_W + 1;

  logic [REGION_W-1:0] region;    // Region of current request
  logic [REGION_W-1:0] region_q;  // Held until the response
  logic                strobe;
  logic                hk_sel, pid_sel;
  logic                err_q;     // Unmapped access answer

  assign region  = m_req_i.addr[`RP_REGION_MSB:REGION_LSB];
  assign strobe  = m_req_i.wen | m_req_i.ren;
  assign hk_sel  = (region == REGION_W'(`RP_REGION_HK));
  assign pid_sel = (region == REGION_W'(`RP_REGION_PID));

  // Address and data fan out, strobes only to the addressed slave
  always_comb begin
    hk_req_o      = m_req_i;
    hk_req_o.wen  = m_req_i.wen & hk_sel;
    hk_req_o.ren  = m_req_i.ren & hk_sel;
    pid_req_o     = m_req_i;
    pid_req_o.wen = m_req_i.wen & pid_sel;
    pid_req_o.ren = m_req_i.ren & pid_sel;
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      region_q <= '0;
      err_q    <= 1'b0;
    end else begin
      err_q <= strobe & ~hk_sel & ~pid_sel;  // Nobody else answers this one
      if (strobe)
        region_q <= region;
    end
  end

  // Response steering
  always_comb begin
    case (region_q)
      REGION_W'(`RP_REGION_HK):  m_rsp_o = hk_rsp_i;
      REGION_W'(`RP_REGION_PID): m_rsp_o = pid_rsp_i;
      default: begin
        m_rsp_o.rdata = '0;
        m_rsp_o.ack   = err_q;
        m_rsp_o.err   = err_q;
      end
    endcase
  end

  // Every answer traces back to a strobe one cycle earlier
  a_ack_after_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    m_rsp_o.ack |-> $past(strobe));

endmodule

`default_nettype wire

// ==== hk_regs.sv ====
// House-keeping registers

`timescale 1ns/1ps
`default_nettype none

`include "rp_analog_settings.svh"

module hk_regs
  import rp_analog_pkg::*;
(
  input  wire logic     adc_clk,
  input  wire logic     rst_i,
  input  wire sys_req_t req_i,
  output sys_rsp_t      rsp_o,
  output hk_cfg_t       cfg_o,
  output pdm_cfg_t      pdm_o,
  output logic [8-1:0]  led_o
);

  localparam int OFS_W = `RP_REGION_MSB - 3;  // Offset inside the region

  logic [OFS_W-1:0]     ofs;
  logic                 loop_q;
  logic [8-1:0]         led_q;
  dac_word_t            dc_a_q, dc_b_q;
  pdm_cfg_t             pdm_q;
  logic [`RP_SYS_DW-1:0] rd_val, rdata_q;
  logic                 ack_q;

  assign ofs = req_i.addr[OFS_W-1:0];

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      loop_q <= 1'b0;
      led_q  <= '0;
      dc_a_q <= '0;
      dc_b_q <= '0;
      pdm_q  <= '0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= req_i.wen | req_i.ren;  // ID writes are acked too
      if (req_i.wen) begin
        case (ofs)
          'h04: loop_q   <= req_i.wdata[0];
          'h08: led_q    <= req_i.wdata[8-1:0];
          'h0C: dc_a_q   <= req_i.wdata[`RP_DAC_DW-1:0];
          'h10: dc_b_q   <= req_i.wdata[`RP_DAC_DW-1:0];
          'h14: pdm_q[0] <= req_i.wdata[`RP_PDM_DW-1:0];
          'h18: pdm_q[1] <= req_i.wdata[`RP_PDM_DW-1:0];
          'h1C: pdm_q[2] <= req_i.wdata[`RP_PDM_DW-1:0];
          'h20: pdm_q[3] <= req_i.wdata[`RP_PDM_DW-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////
  // Read side
  //////////////////////////////

  always_comb begin
    rd_val = '0;  // Unknown offsets read 0
    case (ofs)
      'h00: rd_val                 = `RP_ID_VALUE;
      'h04: rd_val[0]              = loop_q;
      'h08: rd_val[8-1:0]          = led_q;
      'h0C: rd_val[`RP_DAC_DW-1:0] = dc_a_q;  // Raw bits, no sign extension
      'h10: rd_val[`RP_DAC_DW-1:0] = dc_b_q;
      'h14: rd_val[`RP_PDM_DW-1:0] = pdm_q[0];
      'h18: rd_val[`RP_PDM_DW-1:0] = pdm_q[1];
      'h1C: rd_val[`RP_PDM_DW-1:0] = pdm_q[2];
      'h20: rd_val[`RP_PDM_DW-1:0] = pdm_q[3];
      default: ;
    endcase
  end

  always_ff @(posedge adc_clk)
    rdata_q <= req_i.ren ? rd_val : '0;

  assign rsp_o = '{rdata: rdata_q, ack: ack_q, err: 1'b0};
  assign cfg_o = '{digital_loop: loop_q, dc_a: dc_a_q, dc_b: dc_b_q, led: led_q};
  assign pdm_o = pdm_q;
  assign led_o = led_q;

endmodule

`default_nettype wire

// ==== adc_frontend.sv ====
// ADC input stage

`timescale 1ns/1ps
`default_nettype none

`include "rp_analog_settings.svh"

module adc_frontend
  import rp_analog_pkg::*;
(
  input  wire logic                      adc_clk,
  input  wire logic                      rst_i,
  input  wire logic [1:0][`RP_ADC_DW-1:0] adc_dat_i,  // Raw pins, [0] is channel a
  input  wire dac_pair_t                 loop_i,     // Registered DAC words
  input  wire hk_cfg_t                   cfg_i,
  output adc_pair_t                      adc_o
);

  localparam int EXT_W = `RP_ADC_DW - `RP_DAC_DW;
  // Pin code of a zero sample
  localparam logic [`RP_ADC_DW-1:0] ADC_ZERO = {1'b0, {(`RP_ADC_DW-1){1'b1}}};

  logic [1:0][`RP_ADC_DW-1:0] raw_q;  // Input registers
  adc_pair_t                  conv;   // Two's complement

  always_ff @(posedge adc_clk) begin
    if (rst_i)
      raw_q <= {2{ADC_ZERO}};
    else
      raw_q <= adc_dat_i;
  end

  // Negative slope, keep MSB and flip the rest
  assign conv.a = {raw_q[0][`RP_ADC_DW-1], ~raw_q[0][`RP_ADC_DW-2:0]};
  assign conv.b = {raw_q[1][`RP_ADC_DW-1], ~raw_q[1][`RP_ADC_DW-2:0]};

  // Loopback replaces pins with the sign-extended DAC word
  assign adc_o.a = cfg_i.digital_loop ? {{EXT_W{loop_i.a[`RP_DAC_DW-1]}}, loop_i.a} : conv.a;
  assign adc_o.b = cfg_i.digital_loop ? {{EXT_W{loop_i.b[`RP_DAC_DW-1]}}, loop_i.b} : conv.b;

endmodule

`default_nettype wire

// ==== p_controller.sv ====
// Two-channel proportional controller

`timescale 1ns/1ps
`default_nettype none

`include "rp_analog_settings.svh"

module p_controller
  import rp_analog_pkg::*;
(
  input  wire logic      adc_clk,
  input  wire logic      rst_i,
  input  wire sys_req_t  req_i,
  output sys_rsp_t       rsp_o,
  input  wire adc_pair_t adc_i,
  output dac_pair_t      out_o
);

  localparam int CH_N   = 2;
  localparam int OFS_W  = `RP_REGION_MSB - 3;
  localparam int ERR_W  = `RP_ADC_DW + 1;           // Setpoint minus input
  localparam int PROD_W = ERR_W + `RP_ADC_DW;       // Times kp
  localparam int SHR_W  = PROD_W - `RP_KP_SHIFT;    // After the shift

  logic [OFS_W-1:0]      ofs;
  adc_word_t             sp_q [CH_N];
  adc_word_t             kp_q [CH_N];
  adc_word_t             in_d [CH_N];
  dac_word_t             out_q [CH_N];
  logic [`RP_SYS_DW-1:0] rd_val, rdata_q;
  logic                  ack_q;

  assign ofs     = req_i.addr[OFS_W-1:0];
  assign in_d[0] = adc_i.a;
  assign in_d[1] = adc_i.b;

  //////////////////////////////
  // Per channel, 3 stages
  //////////////////////////////

  for (genvar c = 0; c < CH_N; c++) begin : g_ch
    logic signed [ERR_W-1:0]  err_q;
    logic signed [PROD_W-1:0] prod_q;
    logic signed [SHR_W-1:0]  shr;
    logic                     ovf;

    // Setpoint at 8*c, gain at 8*c+4
    always_ff @(posedge adc_clk) begin
      if (rst_i) begin
        sp_q[c] <= '0;
        kp_q[c] <= '0;
      end else if (req_i.wen) begin
        if (ofs == OFS_W'(8*c))     sp_q[c] <= req_i.wdata[`RP_ADC_DW-1:0];
        if (ofs == OFS_W'(8*c + 4)) kp_q[c] <= req_i.wdata[`RP_ADC_DW-1:0];
      end
    end

    assign shr = SHR_W'(prod_q >>> `RP_KP_SHIFT);  // Arithmetic
    // Overflow when bits above the DAC sign disagree with it
    assign ovf = (shr[SHR_W-1:`RP_DAC_DW-1] != '0) && (shr[SHR_W-1:`RP_DAC_DW-1] != '1);

    always_ff @(posedge adc_clk) begin
      if (rst_i) begin
        err_q   <= '0;
        prod_q  <= '0;
        out_q[c] <= '0;
      end else begin
        err_q  <= ERR_W'(sp_q[c]) - ERR_W'(in_d[c]);  // Stage 1
        prod_q <= err_q * kp_q[c];                   // Stage 2, signed
        out_q[c] <= ovf ? {shr[SHR_W-1], {(`RP_DAC_DW-1){~shr[SHR_W-1]}}}  // Stage 3
                        : shr[`RP_DAC_DW-1:0];
      end
    end
  end

  //////////////////////////////
  // Register bus
  //////////////////////////////

  always_comb begin
    rd_val = '0;
    case (ofs)
      'h00: rd_val[`RP_ADC_DW-1:0] = sp_q[0];
      'h04: rd_val[`RP_ADC_DW-1:0] = kp_q[0];
      'h08: rd_val[`RP_ADC_DW-1:0] = sp_q[1];
      'h0C: rd_val[`RP_ADC_DW-1:0] = kp_q[1];
      default: ;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) ack_q <= 1'b0;
    else       ack_q <= req_i.wen | req_i.ren;
  end

  always_ff @(posedge adc_clk)
    rdata_q <= req_i.ren ? rd_val : '0;

  assign rsp_o   = '{rdata: rdata_q, ack: ack_q, err: 1'b0};
  assign out_o.a = out_q[0];
  assign out_o.b = out_q[1];

  // Master and decoder never issue both strobes at once
  a_one_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(req_i.wen && req_i.ren));

endmodule

`default_nettype wire

// ==== dac_backend.sv ====
// DAC output stage

`timescale 1ns/1ps
`default_nettype none

`include "rp_analog_settings.svh"

module dac_backend
  import rp_analog_pkg::*;
(
  input  wire logic            adc_clk,
  input  wire logic            rst_i,
  input  wire dac_pair_t       pid_i,
  input  wire hk_cfg_t         cfg_i,
  output dac_pair_t            dac_o,        // Signed, back to the ADC side
  output logic [`RP_DAC_DW-1:0] dac_dat_a_o, // Offset code to pins
  output logic [`RP_DAC_DW-1:0] dac_dat_b_o
);

  // DC plus controller, clipped to full scale
  function automatic dac_word_t sat_sum(dac_word_t pid, dac_word_t dc);
    logic signed [`RP_DAC_DW:0] sum;  // One extra bit
    sum = (`RP_DAC_DW+1)'(pid) + (`RP_DAC_DW+1)'(dc);
    if (sum[`RP_DAC_DW] ^ sum[`RP_DAC_DW-1])
      return {sum[`RP_DAC_DW], {(`RP_DAC_DW-1){~sum[`RP_DAC_DW]}}};
    return sum[`RP_DAC_DW-1:0];
  endfunction

  // Negative slope offset code
  function automatic logic [`RP_DAC_DW-1:0] to_code(dac_word_t w);
    return {w[`RP_DAC_DW-1], ~w[`RP_DAC_DW-2:0]};
  endfunction

  dac_pair_t sat;

  assign sat.a = sat_sum(pid_i.a, cfg_i.dc_a);
  assign sat.b = sat_sum(pid_i.b, cfg_i.dc_b);

  //////////////////////////////
  // Output registers
  //////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_o       <= '0;
      dac_dat_a_o <= to_code('0);  // Mid scale
      dac_dat_b_o <= to_code('0);
    end else begin
      dac_o       <= sat;
      dac_dat_a_o <= to_code(sat.a);
      dac_dat_b_o <= to_code(sat.b);
    end
  end

endmodule

`default_nettype wire

// ==== pdm_modulator.sv ====
// Slow analog PDM outputs

`timescale 1ns/1ps
`default_nettype none

`include "rp_analog_settings.svh"

module pdm_modulator
  import rp_analog_pkg::*;
(
  input  wire logic            adc_clk,
  input  wire logic            rst_i,
  input  wire pdm_cfg_t        cfg_i,
  output logic [`RP_PDM_N-1:0] pdm_o
);

  localparam int                ACC_W = `RP_PDM_DW + 1;  // Room for the carry
  localparam logic [ACC_W-1:0] MODULUS = ACC_W'((1 << `RP_PDM_DW) - 1);  // 255

  //////////////////////////////
  // One modulator per channel
  //////////////////////////////

  for (genvar c = 0; c < `RP_PDM_N; c++) begin : g_ch
    logic [ACC_W-1:0] acc_q;
    logic [ACC_W-1:0] sum;
    logic             bit_q;

    assign sum = acc_q + ACC_W'(cfg_i[c]);

    always_ff @(posedge adc_clk) begin
      if (rst_i) begin
        acc_q <= '0;
        bit_q <= 1'b0;
      end else if (sum >= MODULUS) begin
        acc_q <= sum - MODULUS;  // Wrap and emit a one
        bit_q <= 1'b1;
      end else begin
        acc_q <= sum;
        bit_q <= 1'b0;
      end
    end

    assign pdm_o[c] = bit_q;

    // Full level carries on every cycle
    a_level_full: assert property (@(posedge adc_clk) disable iff (rst_i)
      (cfg_i[c] == '1) |=> bit_q);

    // Zero level never carries
    a_level_zero: assert property (@(posedge adc_clk) disable iff (rst_i)
      (cfg_i[c] == '0) |=> !bit_q);
  end

endmodule

`default_nettype wire

// ==== rp_analog_top.sv ====
// Analog data path top level

`timescale 1ns/1ps
`default_nettype none

`include "rp_analog_settings.svh"

module rp_analog_top
  import rp_analog_pkg::*;
(
  input  wire logic                      adc_clk,
  input  wire logic                      rst_i,
  // System bus
  input  wire sys_req_t                  sys_req_i,
  output sys_rsp_t                       sys_rsp_o,
  // Fast analog
  input  wire logic [1:0][`RP_ADC_DW-1:0] adc_dat_i,
  output logic [`RP_DAC_DW-1:0]          dac_dat_a_o,
  output logic [`RP_DAC_DW-1:0]          dac_dat_b_o,
  // Slow analog and LEDs
  output logic [`RP_PDM_N-1:0]           dac_pwm_o,
  output logic [8-1:0]                   led_o
);

  sys_req_t  hk_req, pid_req;
  sys_rsp_t  hk_rsp, pid_rsp;
  hk_cfg_t   hk_cfg;
  pdm_cfg_t  pdm_cfg;
  adc_pair_t adc_dat;  // Converted samples
  dac_pair_t pid_dat;  // Controller output
  dac_pair_t dac_dat;  // Saturated DAC words

  //////////////////////////////
  // Bus and registers
  //////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk  (adc_clk),  .rst_i    (rst_i),
    .m_req_i  (sys_req_i), .m_rsp_o  (sys_rsp_o),
    .hk_req_o (hk_req),   .hk_rsp_i (hk_rsp),
    .pid_req_o(pid_req),  .pid_rsp_i(pid_rsp)
  );

  hk_regs i_hk (
    .adc_clk(adc_clk), .rst_i(rst_i),
    .req_i  (hk_req),  .rsp_o(hk_rsp),
    .cfg_o  (hk_cfg),  .pdm_o(pdm_cfg),
    .led_o  (led_o)
  );

  //////////////////////////////
  // Fast path, pin to pin 5 cycles
  //////////////////////////////

  adc_frontend i_adc (
    .adc_clk  (adc_clk),   .rst_i (rst_i),
    .adc_dat_i(adc_dat_i), .loop_i(dac_dat),
    .cfg_i    (hk_cfg),    .adc_o (adc_dat)
  );

  p_controller i_pid (
    .adc_clk(adc_clk), .rst_i(rst_i),
    .req_i  (pid_req), .rsp_o(pid_rsp),
    .adc_i  (adc_dat), .out_o(pid_dat)
  );

  dac_backend i_dac (
    .adc_clk    (adc_clk),     .rst_i      (rst_i),
    .pid_i      (pid_dat),     .cfg_i      (hk_cfg),
    .dac_o      (dac_dat),
    .dac_dat_a_o(dac_dat_a_o), .dac_dat_b_o(dac_dat_b_o)
  );

  pdm_modulator i_pdm (
    .adc_clk(adc_clk), .rst_i(rst_i),
    .cfg_i  (pdm_cfg), .pdm_o(dac_pwm_o)
  );

endmodule

`default_nettype wire

// ==== tb_rp_analog.sv ====
// Analog path testbench

`timescale 1ns/1ps
`default_nettype none

`include "rp_analog_settings.svh"

module tb_rp_analog
  import rp_analog_pkg::*;
();

  localparam int     MAX_CYCLES = 20000;  // Whole run needs under 2000 cycles
  localparam longint DAC_MAX    = (longint'(1) << (`RP_DAC_DW-1)) - 1;
  localparam longint DAC_MIN    = -DAC_MAX - 1;

  typedef logic [`RP_PDM_DW-1:0] pdm_level_t;  // One entry of pdm_cfg_t

  logic                        adc_clk;
  logic                        rst_i;
  sys_req_t                    sys_req;
  sys_rsp_t                    sys_rsp;
  logic [1:0][`RP_ADC_DW-1:0]  adc_dat;
  logic [`RP_DAC_DW-1:0]       dac_a, dac_b;
  logic [`RP_PDM_N-1:0]        pwm;
  logic [8-1:0]                led;

  int          cyc = 0;
  int          err_cnt = 0, chk_cnt = 0, test_cnt = 0, fail_cnt = 0, test_err0 = 0;
  logic [31:0] rng = 32'd69;
  adc_word_t   sp_v [2];  // Controller settings as written
  adc_word_t   kp_v [2];
  dac_word_t   dc_v [2];
  int          due_q [$];  // Cycle at which a DAC sample is due
  dac_word_t   exp_a_q [$], exp_b_q [$];

  rp_analog_top i_rp_analog_top (
    .adc_clk    (adc_clk), .rst_i      (rst_i),
    .sys_req_i  (sys_req), .sys_rsp_o  (sys_rsp),
    .adc_dat_i  (adc_dat),
    .dac_dat_a_o(dac_a),   .dac_dat_b_o(dac_b),
    .dac_pwm_o  (pwm),     .led_o      (led)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  // Cycle count and hang guard
  always @(posedge adc_clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("timeout, run did not end within %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Negative slope pins, MSB kept and the rest flipped
  function automatic adc_word_t adc_value(input logic [`RP_ADC_DW-1:0] raw);
    return adc_word_t'(raw ^ {1'b0, {(`RP_ADC_DW-1){1'b1}}});
  endfunction

  function automatic dac_word_t sat_dac(input longint v);
    if (v > DAC_MAX) return dac_word_t'(DAC_MAX);
    if (v < DAC_MIN) return dac_word_t'(DAC_MIN);
    return dac_word_t'(v);
  endfunction

  function automatic dac_word_t pid_ref(input adc_word_t sp, input adc_word_t kp,
                                        input adc_word_t x);
    longint e;
    e = longint'(sp) - longint'(x);
    return sat_dac((e * longint'(kp)) >>> `RP_KP_SHIFT);  // Floor shift
  endfunction

  function automatic dac_word_t dac_out_ref(input dac_word_t pid, input dac_word_t dc);
    return sat_dac(longint'(pid) + longint'(dc));
  endfunction

  function automatic dac_word_t dac_code(input dac_word_t w);
    return w ^ dac_word_t'(DAC_MAX);
  endfunction

  // Ones in a window, modulus 255
  function automatic pdm_level_t pdm_ones(input pdm_level_t lvl, input int window);
    return pdm_level_t'((int'(lvl) * window) / 255);
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_rsp(input string name, input sys_rsp_t got, input sys_rsp_t exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_dac(input string name, input dac_word_t got, input dac_word_t exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
      err_cnt++;
    end
  endtask

  task automatic check_level(input string name, input pdm_level_t got, input pdm_level_t exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    if (err_cnt == test_err0)
      $display("test %0d %s: ok", test_cnt, name);
    else begin
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
      fail_cnt++;
    end
    test_err0 = err_cnt;
  endtask

  // Streamed samples compared on the falling edge
  always @(negedge adc_clk) begin
    while (due_q.size() != 0 && due_q[0] <= cyc) begin
      if (due_q[0] < cyc) begin
        $display("DAC sample due at cycle %0d was never compared", due_q[0]);
        err_cnt++;
      end else begin
        check_dac("dac_dat_a_o", dac_word_t'(dac_a), exp_a_q[0]);
        check_dac("dac_dat_b_o", dac_word_t'(dac_b), exp_b_q[0]);
      end
      void'(due_q.pop_front());
      void'(exp_a_q.pop_front());
      void'(exp_b_q.pop_front());
    end
  end

  //////////////////////////////
  // Drivers
  //////////////////////////////

  task automatic step(input int n);
    repeat (n) begin
      @(posedge adc_clk);
      #1;
    end
  endtask

  // Strobe for one cycle, response is due right after
  task automatic bus_access(input logic wr, input logic [`RP_SYS_AW-1:0] addr,
                            input logic [`RP_SYS_DW-1:0] wdata, output sys_rsp_t rsp);
    sys_req = '{addr: addr, wdata: wdata, wen: wr, ren: ~wr};
    step(1);
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
    rsp = sys_rsp;
    if (!rsp.ack) begin
      $display("bus access to 0x%05h got no ack one cycle after the strobe", addr);
      err_cnt++;
    end
  endtask

  task automatic bus_write(input logic [`RP_SYS_AW-1:0] addr, input logic [31:0] data);
    sys_rsp_t rsp;
    bus_access(1'b1, addr, data, rsp);
    check_rsp("sys_rsp_o", rsp, '{rdata: '0, ack: 1'b1, err: 1'b0});
  endtask

  task automatic bus_read(input logic [`RP_SYS_AW-1:0] addr, input logic [31:0] exp);
    sys_rsp_t rsp;
    bus_access(1'b0, addr, '0, rsp);
    check_rsp("sys_rsp_o", rsp, '{rdata: exp, ack: 1'b1, err: 1'b0});
  endtask

  task automatic set_pid(input int ch, input adc_word_t sp, input adc_word_t kp);
    bus_write(20'h1_0000 + 20'(8*ch), 32'(sp));
    bus_write(20'h1_0004 + 20'(8*ch), 32'(kp));
    sp_v[ch] = sp;
    kp_v[ch] = kp;
  endtask

  task automatic set_dc(input dac_word_t a, input dac_word_t b);
    bus_write(20'h0_000C, 32'(a));
    bus_write(20'h0_0010, 32'(b));
    dc_v[0] = a;
    dc_v[1] = b;
  endtask

  task automatic check_pins(input dac_word_t exp_a, input dac_word_t exp_b, input int n);
    repeat (n) begin
      check_dac("dac_dat_a_o", dac_word_t'(dac_a), dac_code(exp_a));
      check_dac("dac_dat_b_o", dac_word_t'(dac_b), dac_code(exp_b));
      step(1);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    sys_rsp_t   rsp;
    pdm_level_t lvl [`RP_PDM_N];
    pdm_level_t ones [`RP_PDM_N];
    logic [7:0] led_val;

    rst_i   = 1'b1;
    sys_req = '0;
    adc_dat = {2{16'h7FFF}};  // Zero sample code
    repeat (16) @(posedge adc_clk);
    #1;
    rst_i = 1'b0;
    step(2);

    // Register access and error answer
    bus_read(20'h0_0000, `RP_ID_VALUE);
    bus_write(20'h0_0000, 32'h0);  // ID ignores writes
    bus_read(20'h0_0000, `RP_ID_VALUE);
    bus_write(20'h0_0008, 32'h5A);
    bus_read(20'h0_0008, 32'h5A);
    bus_write(20'h0_000C, 32'h2ABC);
    bus_read(20'h0_000C, 32'h2ABC);
    bus_write(20'h0_0010, 32'hFFFF_F123);  // Upper bits dropped
    bus_read(20'h0_0010, 32'h3123);
    bus_write(20'h0_0004, 32'h1);
    bus_read(20'h0_0004, 32'h1);
    bus_write(20'h0_0004, 32'h0);
    bus_write(20'h0_001C, 32'h1C7);
    bus_read(20'h0_001C, 32'hC7);
    bus_read(20'h0_0040, 32'h0);
    bus_write(20'h1_0000, 32'h0001_2345);
    bus_read(20'h1_0000, 32'h2345);
    bus_write(20'h1_000C, 32'hBEEF);
    bus_read(20'h1_000C, 32'hBEEF);
    bus_access(1'b0, 20'h5_0000, '0, rsp);
    check_rsp("sys_rsp_o", rsp, '{rdata: '0, ack: 1'b1, err: 1'b1});
    bus_access(1'b1, 20'h5_0010, 32'h1234, rsp);
    check_rsp("sys_rsp_o", rsp, '{rdata: '0, ack: 1'b1, err: 1'b1});
    report_test("bus");

    // DC levels straight to the pins
    set_pid(0, 16'sd0, 16'sd0);
    set_pid(1, 16'sd0, 16'sd0);
    set_dc(dac_word_t'(DAC_MAX), dac_word_t'(DAC_MIN));
    step(2);
    check_pins(dc_v[0], dc_v[1], 3);
    set_dc(14'sd0, -14'sd1);
    step(2);
    check_pins(dc_v[0], dc_v[1], 3);
    rng = xorshift32(rng);
    set_dc(dac_word_t'(rng[13:0]), dac_word_t'(rng[29:16]));
    step(2);
    check_pins(dc_v[0], dc_v[1], 3);
    report_test("dc path");

    // Random streaming through the controller
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 2; c++) begin
        rng = xorshift32(rng);
        set_pid(c, adc_word_t'(rng[15:0]), adc_word_t'({{4{rng[27]}}, rng[27:16]}));
      end
      rng = xorshift32(rng);
      set_dc(dac_word_t'({rng[12], rng[12:0]}), dac_word_t'({rng[28], rng[28:16]}));
      step(6);
      for (int i = 0; i < 64; i++) begin
        rng = xorshift32(rng);
        adc_dat[0] = rng[15:0];
        adc_dat[1] = rng[31:16];
        due_q.push_back(cyc + 5);  // Pin to pin latency
        exp_a_q.push_back(dac_code(dac_out_ref(
          pid_ref(sp_v[0], kp_v[0], adc_value(rng[15:0])), dc_v[0])));
        exp_b_q.push_back(dac_code(dac_out_ref(
          pid_ref(sp_v[1], kp_v[1], adc_value(rng[31:16])), dc_v[1])));
        step(1);
      end
      while (due_q.size() != 0)
        step(1);
    end
    report_test("controller");

    // Full scale both ways, then DC on top
    set_dc(14'sd0, 14'sd0);
    set_pid(0, 16'sh7FFF, 16'sh7FFF);
    set_pid(1, -16'sh8000, 16'sh7FFF);
    adc_dat[0] = 16'hFFFF;  // Most negative sample
    adc_dat[1] = 16'h0000;  // Most positive sample
    step(8);
    check_pins(dac_word_t'(DAC_MAX), dac_word_t'(DAC_MIN), 4);
    set_dc(dac_word_t'(DAC_MAX), dac_word_t'(DAC_MIN));
    step(2);
    check_pins(dac_word_t'(DAC_MAX), dac_word_t'(DAC_MIN), 4);
    report_test("saturation");

    // Loopback holds the DAC word when setpoint equals DC
    set_pid(0, 16'sd0, 16'sd0);
    set_pid(1, 16'sd0, 16'sd0);
    rng = xorshift32(rng);
    set_dc(dac_word_t'({rng[12], rng[12:0]}), dac_word_t'({rng[28], rng[28:16]}));
    bus_write(20'h0_0004, 32'h1);
    set_pid(0, adc_word_t'(dc_v[0]), 16'sd0);
    set_pid(1, adc_word_t'(dc_v[1]), 16'sd0);
    rng = xorshift32(rng);
    adc_dat[0] = rng[15:0];
    adc_dat[1] = rng[31:16];
    step(8);
    check_pins(dc_v[0], dc_v[1], 4);
    set_pid(0, sp_v[0], 16'sh0400);  // Gain of 4
    set_pid(1, sp_v[1], -16'sh0400);
    step(10);
    check_pins(dac_out_ref(pid_ref(sp_v[0], kp_v[0], adc_word_t'(dc_v[0])), dc_v[0]),
               dac_out_ref(pid_ref(sp_v[1], kp_v[1], adc_word_t'(dc_v[1])), dc_v[1]), 8);
    bus_write(20'h0_0004, 32'h0);  // Back to the pins
    step(8);
    check_pins(dac_out_ref(pid_ref(sp_v[0], kp_v[0], adc_value(adc_dat[0])), dc_v[0]),
               dac_out_ref(pid_ref(sp_v[1], kp_v[1], adc_value(adc_dat[1])), dc_v[1]), 4);
    report_test("loopback");

    // Slow outputs and LEDs
    rng = xorshift32(rng);
    lvl[0] = 8'd0;
    lvl[1] = 8'd255;
    lvl[2] = 8'd1;
    lvl[3] = rng[7:0];
    led_val = rng[15:8];
    for (int c = 0; c < `RP_PDM_N; c++)
      bus_write(20'h0_0014 + 20'(4*c), 32'(lvl[c]));
    bus_write(20'h0_0008, 32'(led_val));
    step(255);
    for (int c = 0; c < `RP_PDM_N; c++)
      ones[c] = '0;
    repeat (255) begin
      for (int c = 0; c < `RP_PDM_N; c++)
        ones[c] = ones[c] + pdm_level_t'(pwm[c]);
      step(1);
    end
    for (int c = 0; c < `RP_PDM_N; c++)
      check_level($sformatf("dac_pwm_o[%0d] ones", c), ones[c], pdm_ones(lvl[c], 255));
    check_level("led_o", led, led_val);
    report_test("pdm and led");

    $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
             test_cnt, fail_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rp_analog.f ====
+incdir+.
rp_analog_pkg.sv
sys_bus_decoder.sv
hk_regs.sv
adc_frontend.sv
p_controller.sv
dac_backend.sv
pdm_modulator.sv
rp_analog_top.sv
tb_rp_analog.sv

// ==== Makefile ====
TOP = tb_rp_analog

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f rp_analog.f --top-module $(TOP)

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
